/* rtl/state_types_pkg.sv */
package state_types_pkg;

    // ----------------------------------------
    // Geometry
    // ----------------------------------------
    localparam int ID_WID = 4;

    // Per-ID state: 16-bit count plus 8-bit hit counter
    typedef struct packed {
        logic [15:0] count;
        logic [7:0]  hits;
    } state_t;

    // Update opcodes
    typedef enum logic [1:0] {
        UPD_NOP   = 2'd0,
        UPD_ADD   = 2'd1,
        UPD_SET   = 2'd2,
        UPD_CLEAR = 2'd3
    } upd_op_e;

    // Requesting source, datapath wins arbitration
    typedef enum logic {
        SRC_DATAPATH = 1'b0,
        SRC_CONTROL  = 1'b1
    } src_e;

    // ----------------------------------------
    // Request / response / pipeline context
    // ----------------------------------------
    typedef struct packed {
        logic              valid;
        logic [ID_WID-1:0] id;
        upd_op_e           op;
        logic [15:0]       operand;
    } upd_req_t;

    typedef struct packed {
        logic              valid;
        logic [ID_WID-1:0] id;
        state_t            prev;
    } upd_resp_t;

    // Context carried alongside the table read
    typedef struct packed {
        logic              valid;
        src_e              src;
        logic [ID_WID-1:0] id;
        upd_op_e           op;
        logic [15:0]       operand;
        logic              back_to_back;
    } rmw_ctxt_t;

endpackage : state_types_pkg

/* rtl/state_table_pkg.sv */
package state_table_pkg;
    import state_types_pkg::*;

    // ----------------------------------------
    // Table and buffer geometry
    // ----------------------------------------
    localparam int NUM_ENTRIES = 2**ID_WID;

    // Source buffer depth, also initial credits per sender
    localparam int NUM_CREDITS = 2;

    // Buffer pointer and occupancy widths
    localparam int BUF_PTR_WID = (NUM_CREDITS > 1) ? $clog2(NUM_CREDITS) : 1;
    localparam int BUF_CNT_WID = $clog2(NUM_CREDITS + 1);

    // Table read port
    typedef struct packed {
        logic              en;
        logic [ID_WID-1:0] addr;
    } tbl_rd_t;

    // Table write port
    typedef struct packed {
        logic              en;
        logic [ID_WID-1:0] addr;
        state_t            data;
    } tbl_wr_t;

endpackage : state_table_pkg

/* rtl/state_update_mux.sv */
`timescale 1ns/1ps

module state_update_mux
    import state_types_pkg::*;
    import state_table_pkg::*;
(
    input  logic      clk,
    input  logic      srst,
    input  logic      init_done,
    input  upd_req_t  dp_req,
    input  upd_req_t  ctrl_req,
    output logic      dp_credit,
    output logic      ctrl_credit,
    output rmw_ctxt_t issue
);
    // Index 0 is datapath, index 1 is control
    upd_req_t          req_in [2];
    upd_req_t          head [2];
    logic [1:0]        not_empty;
    logic [1:0]        pop;
    logic              sel;
    logic [ID_WID-1:0] last_id;
    logic              last_valid;

    function automatic logic [BUF_PTR_WID-1:0] ptr_inc(input logic [BUF_PTR_WID-1:0] p);
        return (p == BUF_PTR_WID'(NUM_CREDITS - 1)) ? '0 : p + 1'b1;
    endfunction

    assign req_in[0] = dp_req;
    assign req_in[1] = ctrl_req;

    // ----------------------------------------
    // Per-source circular buffers
    // ----------------------------------------
    for (genvar s = 0; s < 2; s++) begin : g_buf
        upd_req_t               mem [NUM_CREDITS];
        logic [BUF_PTR_WID-1:0] wr_ptr;
        logic [BUF_PTR_WID-1:0] rd_ptr;
        logic [BUF_CNT_WID-1:0] count;
        logic                   push;

        assign push         = req_in[s].valid;
        assign head[s]      = mem[rd_ptr];
        assign not_empty[s] = (count != '0);

        always_ff @(posedge clk) begin
            if (push) mem[wr_ptr] <= req_in[s];
        end

        always_ff @(posedge clk) begin
            if (srst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count  <= '0;
            end else begin
                if (push) wr_ptr <= ptr_inc(wr_ptr);
                if (pop[s]) rd_ptr <= ptr_inc(rd_ptr);
                count <= count + BUF_CNT_WID'(push) - BUF_CNT_WID'(pop[s]);
            end
        end

        // Sender must hold a credit, i.e. buffer has room
        a_no_overflow: assert property (@(posedge clk) disable iff (srst)
            push |-> (count != BUF_CNT_WID'(NUM_CREDITS)) || pop[s]);
    end

    // ----------------------------------------
    // Strict-priority issue
    // ----------------------------------------
    always_comb begin
        // Datapath head first, control only when datapath idle
        pop[0] = init_done && not_empty[0];
        pop[1] = init_done && !not_empty[0] && not_empty[1];
        sel    = pop[1];

        issue.valid        = |pop;
        issue.src          = sel ? SRC_CONTROL : SRC_DATAPATH;
        issue.id           = head[sel].id;
        issue.op           = head[sel].op;
        issue.operand      = head[sel].operand;
        // Same id as the request issued one cycle earlier
        issue.back_to_back = (|pop) && last_valid && (head[sel].id == last_id);
    end

    // Credit goes back as the entry leaves its buffer
    assign dp_credit   = pop[0];
    assign ctrl_credit = pop[1];

    // Last issued id stays valid for the very next cycle only
    always_ff @(posedge clk) begin
        if (issue.valid) last_id <= issue.id;
        if (srst) last_valid <= 1'b0;
        else      last_valid <= issue.valid;
    end

endmodule : state_update_mux

/* rtl/state_vector_calc.sv */
`timescale 1ns/1ps

module state_vector_calc
    import state_types_pkg::*;
(
    input  logic        en,
    input  state_t      prev,
    input  upd_op_e     op,
    input  logic [15:0] operand,
    output state_t      next,
    output logic        write_en
);
    // ----------------------------------------
    // Next-state calculation
    // ----------------------------------------
    always_comb begin
        // Default holds state, covers NOP
        next = prev;
        case (op)
            UPD_ADD: begin
                // Both fields wrap naturally
                next.count = prev.count + operand;
                next.hits  = prev.hits + 8'd1;
            end
            UPD_SET: begin
                next.count = operand;
                next.hits  = prev.hits + 8'd1;
            end
            UPD_CLEAR: begin
                next = '0;
            end
            default: begin
                next = prev;
            end
        endcase
    end

    // ----------------------------------------
    // Write gating
    // ----------------------------------------
    // Table only touched when enabled and op modifies state
    // Return state to requester is always prev
    assign write_en = en && (op != UPD_NOP);

endmodule : state_vector_calc

/* rtl/state_table.sv */
`timescale 1ns/1ps

module state_table
    import state_types_pkg::*;
    import state_table_pkg::*;
(
    input  logic    clk,
    input  logic    srst,
    input  tbl_rd_t rd,
    output state_t  rd_data,
    input  tbl_wr_t wr,
    output logic    init_done
);
    state_t            mem [NUM_ENTRIES];
    logic [ID_WID-1:0] sweep_addr;
    logic              sweep_active;
    tbl_wr_t           port_wr;

    // ----------------------------------------
    // Post-reset clearing sweep
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            sweep_addr   <= '0;
            sweep_active <= 1'b1;
            init_done    <= 1'b0;
        end else if (sweep_active) begin
            sweep_addr <= sweep_addr + 1'b1;
            // Last entry cleared this cycle
            if (sweep_addr == ID_WID'(NUM_ENTRIES - 1)) begin
                sweep_active <= 1'b0;
                init_done    <= 1'b1;
            end
        end
    end

    // Sweep owns the write port until done
    always_comb begin
        if (sweep_active) begin
            port_wr.en   = 1'b1;
            port_wr.addr = sweep_addr;
            port_wr.data = '0;
        end else begin
            port_wr = wr;
        end
    end

    // ----------------------------------------
    // Storage with write-first registered read
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (port_wr.en) mem[port_wr.addr] <= port_wr.data;
    end

    always_ff @(posedge clk) begin
        if (rd.en) begin
            // Same-cycle write to same address wins
            if (port_wr.en && (port_wr.addr == rd.addr)) rd_data <= port_wr.data;
            else                                         rd_data <= mem[rd.addr];
        end
    end

    // Core must hold off reads and writes until the sweep completes
    a_no_access_during_init: assert property (@(posedge clk) disable iff (srst)
        !init_done |-> !wr.en && !rd.en);

endmodule : state_table

/* rtl/state_vector_core.sv */
`timescale 1ns/1ps

module state_vector_core
    import state_types_pkg::*;
    import state_table_pkg::*;
(
    input  logic      clk,
    input  logic      srst,
    input  logic      en,
    input  upd_req_t  dp_req,
    input  upd_req_t  ctrl_req,
    output logic      dp_credit,
    output logic      ctrl_credit,
    output upd_resp_t dp_resp,
    output upd_resp_t ctrl_resp,
    output logic      init_done
);
    rmw_ctxt_t issue;
    rmw_ctxt_t s1_ctxt;
    tbl_rd_t   tbl_rd;
    tbl_wr_t   tbl_wr;
    state_t    rd_data;
    state_t    prev_state;
    state_t    next_state;
    state_t    last_next_state;
    logic      last_next_valid;
    logic      fwd_sel;
    logic      calc_write_en;
    upd_resp_t resp_q;
    src_e      resp_src_q;

    // ----------------------------------------
    // Source arbitration
    // ----------------------------------------
    state_update_mux u_state_update_mux (
        .clk         (clk),
        .srst        (srst),
        .init_done   (init_done),
        .dp_req      (dp_req),
        .ctrl_req    (ctrl_req),
        .dp_credit   (dp_credit),
        .ctrl_credit (ctrl_credit),
        .issue       (issue)
    );

    // Table read launches in the issue cycle
    assign tbl_rd.en   = issue.valid;
    assign tbl_rd.addr = issue.id;

    state_table u_state_table (
        .clk       (clk),
        .srst      (srst),
        .rd        (tbl_rd),
        .rd_data   (rd_data),
        .wr        (tbl_wr),
        .init_done (init_done)
    );

    // Stage 1 context lines up with read data
    always_ff @(posedge clk) begin
        s1_ctxt <= issue;
        if (srst) s1_ctxt.valid <= 1'b0;
    end

    // ----------------------------------------
    // Previous state with forwarding
    // ----------------------------------------
    // Write of the prior update not yet in table
    assign fwd_sel    = s1_ctxt.back_to_back && last_next_valid;
    assign prev_state = fwd_sel ? last_next_state : rd_data;

    state_vector_calc u_state_vector_calc (
        .en       (en),
        .prev     (prev_state),
        .op       (s1_ctxt.op),
        .operand  (s1_ctxt.operand),
        .next     (next_state),
        .write_en (calc_write_en)
    );

    // Track what the table will actually hold, which is prev when the write is gated
    always_ff @(posedge clk) begin
        if (s1_ctxt.valid) last_next_state <= calc_write_en ? next_state : prev_state;
        if (srst) last_next_valid <= 1'b0;
        else      last_next_valid <= s1_ctxt.valid;
    end

    // ----------------------------------------
    // Write-back and response
    // ----------------------------------------
    always_ff @(posedge clk) begin
        tbl_wr.addr <= s1_ctxt.id;
        tbl_wr.data <= next_state;
        resp_q.id   <= s1_ctxt.id;
        resp_q.prev <= prev_state;
        resp_src_q  <= s1_ctxt.src;
        if (srst) begin
            tbl_wr.en    <= 1'b0;
            resp_q.valid <= 1'b0;
        end else begin
            tbl_wr.en    <= s1_ctxt.valid && calc_write_en;
            resp_q.valid <= s1_ctxt.valid;
        end
    end

    // Route to requesting source only
    always_comb begin
        dp_resp         = resp_q;
        ctrl_resp       = resp_q;
        dp_resp.valid   = resp_q.valid && (resp_src_q == SRC_DATAPATH);
        ctrl_resp.valid = resp_q.valid && (resp_src_q == SRC_CONTROL);
    end

    // One response port only, that of the source issued two cycles earlier
    a_one_resp: assert property (@(posedge clk) disable iff (srst)
        (dp_resp.valid || ctrl_resp.valid) |->
            $past(issue.valid, 2) && !(dp_resp.valid && ctrl_resp.valid) &&
            (ctrl_resp.valid == ($past(issue.src, 2) == SRC_CONTROL)));

endmodule : state_vector_core

/* bench/state_check_tasks.svh */
`ifndef STATE_CHECK_TASKS_SVH
`define STATE_CHECK_TASKS_SVH

// Error totals, run-wide and per test
int err_count  = 0;
int test_errs  = 0;
int test_count = 0;

task automatic count_error();
    err_count++;
    test_errs++;
endtask

// Protocol or bench failure, not a value mismatch
task automatic report_failure(input string msg);
    $display("Failure in test %0s: %0s", test_name, msg);
    count_error();
endtask

// Returned previous state
task automatic check_state(input string sig, input state_t got, input state_t exp);
    if (got !== exp) begin
        $display("** Error: %0s = %h (count %h hits %h), expected %h (count %h hits %h)",
                 sig, got, got.count, got.hits, exp, exp.count, exp.hits);
        count_error();
    end
endtask

// Id echoed on the source's own response port
task automatic check_src_id(input string sig, input logic [ID_WID-1:0] got,
                            input logic [ID_WID-1:0] exp);
    if (got !== exp) begin
        $display("** Error: %0s = %h, expected %h", sig, got, exp);
        count_error();
    end
endtask

`endif

/* bench/state_vector_core_tb.sv */
`timescale 1ns/1ps

module state_vector_core_tb
    import state_types_pkg::*;
    import state_table_pkg::*;
();
    logic      clk;
    logic      srst;
    logic      en;
    upd_req_t  dp_req;
    upd_req_t  ctrl_req;
    logic      dp_credit;
    logic      ctrl_credit;
    upd_resp_t dp_resp;
    upd_resp_t ctrl_resp;
    logic      init_done;

    // Bench model and bookkeeping
    state_t      model [NUM_ENTRIES];
    upd_resp_t   exp_dp_q [$];
    upd_resp_t   exp_ctrl_q [$];
    int          credits [2];
    logic [1:0]  driven;
    logic [31:0] lcg_state;
    int          limit_cycles;
    int          req_count;
    string       test_name;

    `include "state_check_tasks.svh"

    state_vector_core u_state_vector_core (
        .clk         (clk),
        .srst        (srst),
        .en          (en),
        .dp_req      (dp_req),
        .ctrl_req    (ctrl_req),
        .dp_credit   (dp_credit),
        .ctrl_credit (ctrl_credit),
        .dp_resp     (dp_resp),
        .ctrl_resp   (ctrl_resp),
        .init_done   (init_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------
    // Reference rules
    // ----------------------------------------
    function automatic state_t model_next(input state_t p, input upd_op_e op,
                                          input logic [15:0] v);
        state_t n;
        n = p;
        if (op == UPD_ADD) begin
            n.count = p.count + v;
            n.hits  = p.hits + 8'd1;
        end else if (op == UPD_SET) begin
            n.count = v;
            n.hits  = p.hits + 8'd1;
        end else if (op == UPD_CLEAR) begin
            n = '0;
        end
        return n;
    endfunction

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic bit parse_op(input string s, output upd_op_e op);
        op = UPD_NOP;
        if (s == "NOP") return 1'b1;
        if (s == "ADD") op = UPD_ADD;
        else if (s == "SET") op = UPD_SET;
        else if (s == "CLR") op = UPD_CLEAR;
        else return 1'b0;
        return 1'b1;
    endfunction

    task automatic skip_line(input int f);
        int c;
        c = 0;
        while (c != 10 && c != -1) c = $fgetc(f);
    endtask

    // ----------------------------------------
    // Output sampling on each falling edge
    // ----------------------------------------
    task automatic check_response(input string port, input upd_resp_t got, input int s);
        upd_resp_t exp;
        if ((s == 0 && exp_dp_q.size() == 0) || (s == 1 && exp_ctrl_q.size() == 0)) begin
            report_failure({port, " went valid with no request outstanding on that source"});
        end else begin
            if (s == 0) exp = exp_dp_q.pop_front();
            else exp = exp_ctrl_q.pop_front();
            check_src_id({port, ".id"}, got.id, exp.id);
            check_state({port, ".prev"}, got.prev, exp.prev);
        end
    endtask

    task automatic sample_outputs();
        if (dp_credit) credits[0]++;
        if (ctrl_credit) credits[1]++;
        // More credits back than were ever spent
        for (int s = 0; s < 2; s++) begin
            if (credits[s] > NUM_CREDITS) begin
                report_failure($sformatf("source %0d got back more credits than it sent", s));
                credits[s] = NUM_CREDITS;
            end
        end
        if (dp_resp.valid) check_response("dp_resp", dp_resp, 0);
        if (ctrl_resp.valid) check_response("ctrl_resp", ctrl_resp, 1);
    endtask

    // Request valids drop each clock unless driven again
    task automatic step();
        @(negedge clk);
        dp_req.valid   = 1'b0;
        ctrl_req.valid = 1'b0;
        driven         = 2'b00;
        sample_outputs();
    endtask

    task automatic drain();
        while (exp_dp_q.size() != 0 || exp_ctrl_q.size() != 0) step();
    endtask

    task automatic finish_test();
        if (test_count > 0) begin
            drain();
            $display("Test %0d %0s: %0s, %0d errors", test_count, test_name,
                     (test_errs == 0) ? "pass" : "FAIL", test_errs);
        end
    endtask

    // ----------------------------------------
    // Request issue with credit gating
    // ----------------------------------------
    task automatic issue_request(input int s, input logic [ID_WID-1:0] id, input upd_op_e op,
                                 input logic [15:0] operand, input logic en_v,
                                 input logic has_exp, input state_t file_exp);
        state_t    prev;
        upd_req_t  req;
        upd_resp_t exp;
        // en is global, so change it only with nothing in flight
        if (en_v !== en) begin
            drain();
            en = en_v;
        end
        if (driven[s]) step();
        while (credits[s] == 0) step();
        // Model runs in drive order
        prev = model[id];
        if (en_v && op != UPD_NOP) model[id] = model_next(prev, op, operand);
        if (has_exp && file_exp !== prev) begin
            report_failure($sformatf("test file expects %h for id %h but the model gives %h",
                                     file_exp, id, prev));
        end
        exp.valid   = 1'b1;
        exp.id      = id;
        exp.prev    = has_exp ? file_exp : prev;
        req.valid   = 1'b1;
        req.id      = id;
        req.op      = op;
        req.operand = operand;
        if (s == 0) begin
            exp_dp_q.push_back(exp);
            dp_req = req;
        end else begin
            exp_ctrl_q.push_back(exp);
            ctrl_req = req;
        end
        credits[s]--;
        driven[s] = 1'b1;
        req_count++;
    endtask

    // Request count of the file sizes the watchdog
    task automatic count_requests(output int total);
        int    cfd;
        int    n;
        int    reps;
        string cmd;
        string f1;
        string f2;
        string f3;
        string f4;
        total = 0;
        cfd = $fopen("bench/state_vector_tests.txt", "r");
        if (cfd != 0) begin
            while ($fscanf(cfd, "%s", cmd) == 1) begin
                if (cmd == "B") begin
                    n = $fscanf(cfd, "%s %s %s %s %d", f1, f2, f3, f4, reps);
                    if (n == 5) total += reps;
                end else begin
                    if (cmd == "D" || cmd == "C") total++;
                    if (cmd == "Z") total += NUM_ENTRIES;
                    skip_line(cfd);
                end
            end
            $fclose(cfd);
        end
    endtask

    // Watchdog
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog: run did not finish in %0d cycles, a response or credit is missing",
                 limit_cycles);
        $display("Done: errors found");
        $finish;
    end

    // ----------------------------------------
    // Main stimulus
    // ----------------------------------------
    initial begin
        int                fd;
        int                n;
        int                reps;
        int                en_i;
        int                total;
        int                init_cycles;
        string             cmd;
        string             src_s;
        string             op_s;
        string             opnd_s;
        string             cnt_s;
        string             hits_s;
        logic [ID_WID-1:0] id;
        logic [15:0]       operand;
        logic [15:0]       cnt_v;
        logic [7:0]        hits_v;
        logic              has_exp;
        upd_op_e           op;
        state_t            file_exp;

        srst       = 1'b1;
        en         = 1'b1;
        dp_req     = '0;
        ctrl_req   = '0;
        driven     = 2'b00;
        lcg_state  = 32'h8d5e;
        req_count  = 0;
        test_name  = "none";
        credits[0] = NUM_CREDITS;
        credits[1] = NUM_CREDITS;
        for (int i = 0; i < NUM_ENTRIES; i++) model[i] = '0;
        count_requests(total);
        limit_cycles = total * 10 + 200;

        repeat (4) @(negedge clk);
        srst = 1'b0;
        // Clearing sweep takes one cycle per entry
        init_cycles = 0;
        while (!init_done) begin
            step();
            init_cycles++;
        end
        if (init_cycles != NUM_ENTRIES) begin
            report_failure($sformatf("init_done rose %0d cycles after reset, expected %0d",
                                     init_cycles, NUM_ENTRIES));
        end

        fd = $fopen("bench/state_vector_tests.txt", "r");
        if (fd == 0) report_failure("cannot open bench/state_vector_tests.txt");
        while (fd != 0 && $fscanf(fd, "%s", cmd) == 1) begin
            if (cmd == "#") begin
                skip_line(fd);
            end else if (cmd == "T") begin
                n = $fscanf(fd, "%s", src_s);
                finish_test();
                test_count++;
                test_name = src_s;
                test_errs = 0;
            end else if (cmd == "W") begin
                n = $fscanf(fd, "%d", reps);
                repeat (reps + 1) step();
            end else if (cmd == "Z") begin
                // NOP sweep where every id must read back zero
                n = $fscanf(fd, "%s", src_s);
                for (int i = 0; i < NUM_ENTRIES; i++) begin
                    issue_request((src_s == "C") ? 1 : 0, ID_WID'(i), UPD_NOP, 16'h0,
                                  1'b1, 1'b1, '0);
                end
            end else if (cmd == "B") begin
                n = $fscanf(fd, "%s %h %s %s %d", src_s, id, op_s, opnd_s, reps);
                if (n != 5 || !parse_op(op_s, op)) begin
                    report_failure("malformed burst line in test file");
                end else begin
                    n = $sscanf(opnd_s, "%h", operand);
                    repeat (reps) issue_request((src_s == "C") ? 1 : 0, id, op, operand,
                                                1'b1, 1'b0, '0);
                end
            end else if (cmd == "D" || cmd == "C") begin
                n = $fscanf(fd, "%h %s %s %d %s %s", id, op_s, opnd_s, en_i, cnt_s, hits_s);
                if (n != 6 || !parse_op(op_s, op)) begin
                    report_failure("malformed request line in test file");
                end else begin
                    if (opnd_s == "R") operand = lcg_next();
                    else n = $sscanf(opnd_s, "%h", operand);
                    // A dash leaves the expected state to the model
                    has_exp  = (cnt_s != "-") && (hits_s != "-");
                    file_exp = '0;
                    if (has_exp) begin
                        n = $sscanf(cnt_s, "%h", cnt_v);
                        n = $sscanf(hits_s, "%h", hits_v);
                        file_exp.count = cnt_v;
                        file_exp.hits  = hits_v;
                    end
                    issue_request((cmd == "C") ? 1 : 0, id, op, operand, (en_i != 0),
                                  has_exp, file_exp);
                end
            end else begin
                report_failure({"unknown command ", cmd, " in test file"});
                skip_line(fd);
            end
        end
        finish_test();
        drain();
        if (fd != 0) $fclose(fd);

        $display("Summary: %0d tests, %0d requests, %0d errors",
                 test_count, req_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule : state_vector_core_tb

/* bench/state_vector_tests.txt */
# T name | W idle | Z src | B src id op operand count
# D/C id op operand en exp_count exp_hits, operand R is random, exp - comes from the model
T post_reset
Z D
Z C
T opcodes
D 1 ADD 0010 1 0000 00
D 1 ADD fff8 1 0010 01
D 1 SET 1234 1 0008 02
D 1 CLR 0000 1 1234 03
D 1 NOP 0000 1 0000 00
B D 2 ADD 0001 256
D 2 SET 0042 1 0100 00
C 2 NOP 0000 1 0042 01
T forwarding
D 3 ADD 0001 1 0000 00
D 3 ADD 0002 1 0001 01
W 1
D 3 ADD 0004 1 0003 02
W 2
D 3 ADD 0008 1 0007 03
D 3 ADD R 1 000f 04
D 3 NOP 0000 1 - -
T enable
D 4 SET 00aa 1 0000 00
D 4 ADD 0005 0 00aa 01
D 4 CLR 0000 0 00aa 01
D 4 NOP 0000 1 00aa 01
T priority
D 6 ADD 0001 1 0000 00
C 9 SET 0100 1 0000 00
D 6 ADD 0001 1 0001 01
C 9 ADD 0001 1 0100 01
C e SET 0abc 1 0000 00
D d NOP 0000 1 0000 00

/* list.f */
+incdir+bench
rtl/state_types_pkg.sv
rtl/state_table_pkg.sv
rtl/state_update_mux.sv
rtl/state_vector_calc.sv
rtl/state_table.sv
rtl/state_vector_core.sv
bench/state_vector_core_tb.sv

/* Makefile */
SIM := obj_dir/Vstate_vector_core_tb

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): list.f $(wildcard rtl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)
	verilator --binary --timing --assert -j 0 --top-module state_vector_core_tb -f list.f

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@if ! grep -q "Done: no errors" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
